/* verilog/rmt_pkg.sv */
`default_nettype none

package rmt_pkg;

	localparam int DATA_W = 64;
	localparam int KEEP_W = DATA_W / 8;
	localparam int CONTAINER_W = 16;
	localparam int NUM_CONTAINERS = 4;
	// phv sits in the low bits of a first beat
	localparam int PHV_W = CONTAINER_W * NUM_CONTAINERS;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [KEEP_W-1:0] keep;
		logic last;
		// configuration beat, never forwarded to the output
		logic is_ctrl;
	} beat_t;

	typedef logic [CONTAINER_W-1:0] container_t;

	// container i maps to data bits 16i+15:16i
	typedef container_t [NUM_CONTAINERS-1:0] phv_t;

	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_SET = 2'd1,
		OP_ADD = 2'd2
	} op_t;

	typedef struct packed {
		logic valid;
		logic [15:0] key;
		op_t op;
		logic [1:0] dst;
		logic [15:0] operand;
	} entry_t;

	// control beat data layout
	//   15:0   key
	//   31:16  operand
	//   33:32  destination container
	//   35:34  op
	//   39:36  entry index
	//   47:40  stage id
	// entry valid whenever op != OP_NOP
	typedef struct packed {
		logic valid;
		logic [7:0] stage_id;
		logic [3:0] index;
		entry_t entry;
	} cfg_t;

endpackage

`default_nettype wire

/* verilog/sync_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

module sync_fifo #(
	parameter type item_t = logic,
	parameter int DEPTH = 16
) (
	input wire logic clk,
	input wire logic aresetn,
	input wire logic push,
	input wire item_t din,
	input wire logic pop,
	output item_t dout,
	output logic full,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] free
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	item_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	// head of queue is always presented
	assign dout = mem[rd_ptr];
	assign full = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign free = CW'(DEPTH) - count;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// net occupancy change
			count <= count + CW'(push) - CW'(pop);
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!aresetn) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!aresetn) pop |-> !empty);

endmodule

`default_nettype wire

/* verilog/pkt_filter.sv */
`default_nettype none
`timescale 1ns/100ps

module pkt_filter import rmt_pkg::*; (
	input wire logic clk,
	input wire logic aresetn,
	input wire beat_t s_beat,
	input wire logic s_valid,
	output logic s_ready,
	output beat_t d_beat,
	output logic d_valid,
	input wire logic d_ready,
	output cfg_t cfg
);

	logic ctrl_take;
	op_t op_dec;

	// no back-pressure of its own
	assign s_ready = d_ready;

	// data beats go straight on to the parser
	assign d_beat = s_beat;
	assign d_valid = s_valid && !s_beat.is_ctrl;

	assign ctrl_take = s_valid && s_ready && s_beat.is_ctrl;
	assign op_dec = op_t'(s_beat.data[35:34]);

	// table write decode, one cycle pulse per control beat
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			cfg <= '0;
		end else begin
			cfg.valid <= ctrl_take;
			cfg.stage_id <= s_beat.data[47:40];
			cfg.index <= s_beat.data[39:36];
			cfg.entry.valid <= (op_dec != OP_NOP);
			cfg.entry.key <= s_beat.data[15:0];
			cfg.entry.operand <= s_beat.data[31:16];
			cfg.entry.dst <= s_beat.data[33:32];
			cfg.entry.op <= op_dec;
		end
	end

	// table writes are single beat only
	a_ctrl_single: assert property (@(posedge clk) disable iff (!aresetn)
		(s_valid && s_beat.is_ctrl) |-> s_beat.last);

endmodule

`default_nettype wire

/* verilog/phv_parser.sv */
`default_nettype none
`timescale 1ns/100ps

module phv_parser import rmt_pkg::*; #(
	parameter int NUM_STAGES = 3,
	parameter int PHV_DEPTH = 8
) (
	input wire logic clk,
	input wire logic aresetn,
	input wire beat_t s_beat,
	input wire logic s_valid,
	output logic s_ready,
	output logic fifo_push,
	output beat_t fifo_beat,
	input wire logic fifo_full,
	input wire logic [$clog2(PHV_DEPTH+1)-1:0] phv_free,
	output phv_t phv,
	output logic phv_valid
);

	localparam int FW = $clog2(PHV_DEPTH + 1);
	// one slot per stage, the parser register and the new packet
	localparam logic [FW-1:0] ROOM = FW'(NUM_STAGES + 2);

	logic up;
	logic in_pkt;
	logic room_ok;
	logic take;
	logic first_take;

	assign room_ok = (phv_free >= ROOM);

	// first beat also needs room in the phv fifo
	assign s_ready = up && !fifo_full && (in_pkt || room_ok);
	assign take = s_valid && s_ready;
	assign first_take = take && !in_pkt;

	assign fifo_push = take;
	assign fifo_beat = s_beat;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			up <= 1'b0;
			in_pkt <= 1'b0;
			phv_valid <= 1'b0;
		end else begin
			// input held off for the first cycle out of reset
			up <= 1'b1;
			if (take) begin
				in_pkt <= !s_beat.last;
			end
			phv_valid <= first_take;
		end
	end

	always_ff @(posedge clk) begin
		if (first_take) begin
			phv <= phv_t'(s_beat.data[PHV_W-1:0]);
		end
	end

endmodule

`default_nettype wire

/* verilog/match_action_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module match_action_stage import rmt_pkg::*; #(
	parameter int STAGE_ID = 0,
	parameter int TABLE_DEPTH = 4
) (
	input wire logic clk,
	input wire logic aresetn,
	input wire phv_t phv_in,
	input wire logic phv_valid_in,
	input wire cfg_t cfg_in,
	output phv_t phv_out,
	output logic phv_valid_out,
	output cfg_t cfg_out
);

	localparam int IDX_W = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;
	localparam logic [7:0] MY_ID = 8'(STAGE_ID);

	entry_t table_q [TABLE_DEPTH];
	logic wr_hit;
	logic wr_en;
	logic [IDX_W-1:0] wr_idx;
	logic hit;
	entry_t sel;
	phv_t phv_next;

	assign wr_hit = cfg_in.valid && (cfg_in.stage_id == MY_ID);
	assign wr_en = wr_hit && (int'(cfg_in.index) < TABLE_DEPTH);
	assign wr_idx = cfg_in.index[IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < TABLE_DEPTH; i++) begin
				table_q[i].valid <= 1'b0;
			end
		end else if (wr_en) begin
			table_q[wr_idx] <= cfg_in.entry;
		end
	end

	// scan high to low so the lowest matching index wins
	always_comb begin
		hit = 1'b0;
		sel = '0;
		for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
			if (table_q[i].valid && (table_q[i].key == phv_in[0])) begin
				hit = 1'b1;
				sel = table_q[i];
			end
		end
	end

	always_comb begin
		phv_next = phv_in;
		if (hit) begin
			case (sel.op)
				OP_SET: phv_next[sel.dst] = sel.operand;
				// wraps at 16 bits
				OP_ADD: phv_next[sel.dst] = phv_in[sel.dst] + sel.operand;
				default: phv_next = phv_in;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			phv_valid_out <= 1'b0;
			cfg_out <= '0;
		end else begin
			phv_valid_out <= phv_valid_in;
			// writes follow the phvs down the chain
			cfg_out <= cfg_in;
		end
	end

	always_ff @(posedge clk) begin
		phv_out <= phv_next;
	end

	// control software must address only existing entries
	a_index_range: assert property (@(posedge clk) disable iff (!aresetn)
		wr_hit |-> (int'(cfg_in.index) < TABLE_DEPTH));

endmodule

`default_nettype wire

/* verilog/deparser.sv */
`default_nettype none
`timescale 1ns/100ps

module deparser import rmt_pkg::*; (
	input wire logic clk,
	input wire logic aresetn,
	input wire beat_t pay_beat,
	input wire logic pay_empty,
	output logic pay_pop,
	input wire phv_t phv,
	input wire logic phv_empty,
	output logic phv_pop,
	output beat_t m_beat,
	output logic m_valid,
	input wire logic m_ready
);

	logic in_pkt;
	logic can_load;
	beat_t merged;

	// output register free or draining this cycle
	assign can_load = !m_valid || m_ready;

	// first beat waits until its phv has left the stage chain
	assign pay_pop = can_load && !pay_empty && (in_pkt || !phv_empty);
	assign phv_pop = pay_pop && !in_pkt;

	always_comb begin
		merged = pay_beat;
		if (!in_pkt) begin
			merged.data[PHV_W-1:0] = phv;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			in_pkt <= 1'b0;
			m_valid <= 1'b0;
		end else begin
			if (pay_pop) begin
				in_pkt <= !pay_beat.last;
				m_valid <= 1'b1;
			end else if (m_ready) begin
				m_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pay_pop) begin
			m_beat <= merged;
		end
	end

	// a waiting phv always has its first beat queued ahead of it
	a_phv_paired: assert property (@(posedge clk) disable iff (!aresetn)
		(!in_pkt && !phv_empty) |-> !pay_empty);

endmodule

`default_nettype wire

/* verilog/rmt_pipeline_top.sv */
`default_nettype none
`timescale 1ns/100ps

module rmt_pipeline_top import rmt_pkg::*; #(
	parameter int NUM_STAGES = 3,
	parameter int TABLE_DEPTH = 4,
	parameter int PAYLOAD_DEPTH = 16,
	parameter int PHV_DEPTH = 8
) (
	input wire logic clk,
	input wire logic aresetn,
	input wire beat_t s_beat,
	input wire logic s_valid,
	output logic s_ready,
	output beat_t m_beat,
	output logic m_valid,
	input wire logic m_ready
);

	beat_t d_beat;
	logic d_valid;
	logic d_ready;

	logic pay_push;
	beat_t pay_din;
	beat_t pay_dout;
	logic pay_pop;
	logic pay_full;
	logic pay_empty;

	phv_t phv_dout;
	logic phv_pop;
	logic phv_empty;
	logic [$clog2(PHV_DEPTH+1)-1:0] phv_free;

	// index 0 feeds stage 0, index NUM_STAGES leaves the last stage
	phv_t stg_phv [NUM_STAGES+1];
	logic stg_valid [NUM_STAGES+1];
	cfg_t stg_cfg [NUM_STAGES+1];

	pkt_filter filter_i (
		.clk(clk),
		.aresetn(aresetn),
		.s_beat(s_beat),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.d_beat(d_beat),
		.d_valid(d_valid),
		.d_ready(d_ready),
		.cfg(stg_cfg[0])
	);

	phv_parser #(
		.NUM_STAGES(NUM_STAGES),
		.PHV_DEPTH(PHV_DEPTH)
	) parser_i (
		.clk(clk),
		.aresetn(aresetn),
		.s_beat(d_beat),
		.s_valid(d_valid),
		.s_ready(d_ready),
		.fifo_push(pay_push),
		.fifo_beat(pay_din),
		.fifo_full(pay_full),
		.phv_free(phv_free),
		.phv(stg_phv[0]),
		.phv_valid(stg_valid[0])
	);

	for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
		match_action_stage #(
			.STAGE_ID(g),
			.TABLE_DEPTH(TABLE_DEPTH)
		) stage_i (
			.clk(clk),
			.aresetn(aresetn),
			.phv_in(stg_phv[g]),
			.phv_valid_in(stg_valid[g]),
			.cfg_in(stg_cfg[g]),
			.phv_out(stg_phv[g+1]),
			.phv_valid_out(stg_valid[g+1]),
			.cfg_out(stg_cfg[g+1])
		);
	end

	sync_fifo #(
		.item_t(beat_t),
		.DEPTH(PAYLOAD_DEPTH)
	) pay_fifo_i (
		.clk(clk),
		.aresetn(aresetn),
		.push(pay_push),
		.din(pay_din),
		.pop(pay_pop),
		.dout(pay_dout),
		.full(pay_full),
		.empty(pay_empty),
		.free()
	);

	sync_fifo #(
		.item_t(phv_t),
		.DEPTH(PHV_DEPTH)
	) phv_fifo_i (
		.clk(clk),
		.aresetn(aresetn),
		.push(stg_valid[NUM_STAGES]),
		.din(stg_phv[NUM_STAGES]),
		.pop(phv_pop),
		.dout(phv_dout),
		.full(),
		.empty(phv_empty),
		.free(phv_free)
	);

	deparser deparser_i (
		.clk(clk),
		.aresetn(aresetn),
		.pay_beat(pay_dout),
		.pay_empty(pay_empty),
		.pay_pop(pay_pop),
		.phv(phv_dout),
		.phv_empty(phv_empty),
		.phv_pop(phv_pop),
		.m_beat(m_beat),
		.m_valid(m_valid),
		.m_ready(m_ready)
	);

endmodule

`default_nettype wire

/* dv/rmt_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module rmt_tb import rmt_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_STAGES = 3;
	localparam int TABLE_DEPTH = 4;
	localparam int T1_PKTS = 6;
	localparam int T5_PKTS = 40;
	localparam int MAX_LEN = 4;
	// directed tests add roughly 30 beats on top of the random ones
	localparam int TOTAL_BEATS = T1_PKTS * MAX_LEN + T5_PKTS + 30;
	localparam int BEAT_MARGIN = 12;
	localparam int WATCHDOG_NS = CLK_PERIOD * (RESET_CYCLES + TOTAL_BEATS * BEAT_MARGIN);

	logic clk = 1'b0;
	logic aresetn;
	beat_t s_beat;
	logic s_valid;
	logic s_ready;
	beat_t m_beat;
	logic m_valid;
	logic m_ready;

	logic [15:0] stim_lfsr = 16'd48402;
	logic [15:0] rdy_lfsr = 16'd48402;
	logic ready_rand = 1'b0;

	entry_t model_tbl [NUM_STAGES][TABLE_DEPTH];
	beat_t exp_q [$];
	beat_t exp_b;
	int errors = 0;
	int checks = 0;
	int test_num = 0;
	int test_err0;
	int test_chk0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	rmt_pipeline_top dut_i (
		.clk(clk),
		.aresetn(aresetn),
		.s_beat(s_beat),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.m_beat(m_beat),
		.m_valid(m_valid),
		.m_ready(m_ready)
	);

	// taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[62:0], stim_lfsr[15]};
			stim_lfsr = lfsr_next(stim_lfsr);
		end
		return r;
	endfunction

	// expected phv after the whole stage chain
	function automatic phv_t ref_phv(input phv_t p);
		phv_t r;
		entry_t e;
		bit found;
		r = p;
		for (int s = 0; s < NUM_STAGES; s++) begin
			found = 1'b0;
			e = '0;
			for (int i = 0; i < TABLE_DEPTH; i++) begin
				if (!found && model_tbl[s][i].valid && model_tbl[s][i].key == r[0]) begin
					found = 1'b1;
					e = model_tbl[s][i];
				end
			end
			if (found && e.op == OP_SET) begin
				r[e.dst] = e.operand;
			end else if (found && e.op == OP_ADD) begin
				r[e.dst] = r[e.dst] + e.operand;
			end
		end
		return r;
	endfunction

	task automatic check_beat(input beat_t got, input beat_t exp);
		checks++;
		if (got.data !== exp.data) begin
			errors++;
			$display("FAILED m_beat.data got %h expected %h", got.data, exp.data);
		end
		if (got.keep !== exp.keep) begin
			errors++;
			$display("FAILED m_beat.keep got %h expected %h", got.keep, exp.keep);
		end
		if (got.last !== exp.last) begin
			errors++;
			$display("FAILED m_beat.last got %h expected %h", got.last, exp.last);
		end
	endtask

	task automatic check_logic(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// output side, every accepted beat against the model queue
	always @(posedge clk) begin
		if (aresetn && m_valid && m_ready) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("output beat arrived while no packet was outstanding");
			end else begin
				exp_b = exp_q.pop_front();
				check_beat(m_beat, exp_b);
			end
		end
	end

	initial begin
		m_ready = 1'b0;
		forever begin
			@(negedge clk);
			if (ready_rand) begin
				m_ready = rdy_lfsr[15];
				rdy_lfsr = lfsr_next(rdy_lfsr);
			end else begin
				m_ready = 1'b1;
			end
		end
	end

	task automatic send_beat(input beat_t b);
		@(negedge clk);
		s_beat = b;
		s_valid = 1'b1;
		@(posedge clk);
		while (!s_ready) begin
			@(posedge clk);
		end
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		s_valid = 1'b0;
	endtask

	task automatic write_entry(input int stage, input int index, input op_t op,
			input logic [1:0] dst, input logic [15:0] key, input logic [15:0] operand);
		beat_t b;
		b = '0;
		b.data[15:0] = key;
		b.data[31:16] = operand;
		b.data[33:32] = dst;
		b.data[35:34] = op;
		b.data[39:36] = 4'(index);
		b.data[47:40] = 8'(stage);
		b.keep = 8'hff;
		b.last = 1'b1;
		b.is_ctrl = 1'b1;
		send_beat(b);
		model_tbl[stage][index].valid = (op != OP_NOP);
		model_tbl[stage][index].key = key;
		model_tbl[stage][index].op = op;
		model_tbl[stage][index].dst = dst;
		model_tbl[stage][index].operand = operand;
	endtask

	task automatic send_packet(input int len, input logic [15:0] c0, input bit use_c0,
			input bit gaps);
		beat_t b;
		beat_t e;
		for (int i = 0; i < len; i++) begin
			b.data = take_bits(DATA_W);
			if (i == 0 && use_c0) begin
				b.data[15:0] = c0;
			end
			b.last = (i == len - 1);
			b.keep = b.last ? (8'(take_bits(8)) | 8'h01) : 8'hff;
			b.is_ctrl = 1'b0;
			e = b;
			if (i == 0) begin
				e.data[PHV_W-1:0] = ref_phv(phv_t'(b.data[PHV_W-1:0]));
			end
			exp_q.push_back(e);
			if (gaps && take_bits(2) == 0) begin
				idle_cycle();
			end
			send_beat(b);
		end
	endtask

	task automatic start_test();
		test_num++;
		test_err0 = errors;
		test_chk0 = checks;
	endtask

	task automatic end_test(input string name);
		idle_cycle();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		$display("test %0d %s: %0d checks, %0d mismatches", test_num, name,
			checks - test_chk0, errors - test_err0);
	endtask

	initial begin
		logic [15:0] pick;
		s_beat = '0;
		s_valid = 1'b0;
		aresetn = 1'b0;
		for (int s = 0; s < NUM_STAGES; s++) begin
			for (int i = 0; i < TABLE_DEPTH; i++) begin
				model_tbl[s][i] = '0;
			end
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;

		start_test();
		check_logic("m_valid", m_valid, 1'b0);
		// input side still closed in the first cycle out of reset
		check_logic("s_ready", s_ready, 1'b0);
		for (int p = 0; p < T1_PKTS; p++) begin
			send_packet(1 + int'(take_bits(2)), 16'h0, 1'b0, 1'b1);
		end
		end_test("empty tables");

		start_test();
		write_entry(1, 0, OP_SET, 2'd2, 16'h1234, 16'ha5a5);
		send_packet(3, 16'h1234, 1'b1, 1'b0);
		send_packet(2, 16'h4321, 1'b1, 1'b0);
		end_test("stage 1 set");

		// fff0 + 0020 wraps to 0010, which stage 2 matches
		start_test();
		write_entry(0, 0, OP_ADD, 2'd0, 16'hfff0, 16'h0020);
		write_entry(2, 0, OP_SET, 2'd3, 16'h0010, 16'hbeef);
		send_packet(2, 16'hfff0, 1'b1, 1'b0);
		send_packet(1, 16'h0010, 1'b1, 1'b0);
		end_test("chained add");

		start_test();
		write_entry(1, 1, OP_SET, 2'd2, 16'h5555, 16'h1111);
		write_entry(1, 2, OP_SET, 2'd2, 16'h5555, 16'h2222);
		send_packet(2, 16'h5555, 1'b1, 1'b0);
		write_entry(1, 1, OP_NOP, 2'd0, 16'h5555, 16'h0000);
		send_packet(2, 16'h5555, 1'b1, 1'b0);
		end_test("priority and overwrite");

		start_test();
		@(posedge clk);
		ready_rand = 1'b1;
		for (int p = 0; p < T5_PKTS; p++) begin
			case (int'(take_bits(2)))
				0: pick = 16'h1234;
				1: pick = 16'hfff0;
				2: pick = 16'h5555;
				default: pick = 16'(take_bits(16));
			endcase
			// a write in the middle of traffic applies to later packets only
			if (p == T5_PKTS / 2) begin
				write_entry(2, 1, OP_ADD, 2'd1, 16'h1234, 16'h0101);
			end
			send_packet(1, pick, 1'b1, 1'b1);
		end
		end_test("back-pressure");
		@(posedge clk);
		ready_rand = 1'b0;

		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run hung with %0d output beats still expected", exp_q.size());
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
verilog/rmt_pkg.sv
verilog/sync_fifo.sv
verilog/pkt_filter.sv
verilog/phv_parser.sv
verilog/match_action_stage.sv
verilog/deparser.sv
verilog/rmt_pipeline_top.sv
dv/rmt_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module rmt_tb -f project.f -o rmt_sim

./obj_dir/rmt_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0
